// File: src.f
rtl/core_pkg.sv
rtl/instr_fetch.sv
rtl/instr_decode.sv
rtl/execute_stage.sv
rtl/result_stage.sv
rtl/hazard_unit.sv
rtl/pipeline_core.sv
testbench/tb_clock.sv
testbench/tb_pipeline_core.sv

// File: testbench/tb_pipeline_core.sv
`timescale 1ns/1ns

module tb_pipeline_core;

    localparam core_pkg::word_t reset_pc = 32'h0000_0100;

    logic                clk, rstN, reset_req;
    core_pkg::word_t     imem_data, imem_addr;
    logic                dmem_ready, dmem_valid, dmem_we;
    core_pkg::word_t     dmem_rdata, dmem_addr, dmem_wdata;
    logic                retire_valid;
    core_pkg::reg_addr_t retire_rd;
    core_pkg::word_t     retire_data;

    // Instruction and data memory contents.
    core_pkg::word_t     imem [64];
    core_pkg::word_t     dmem [256];
    int unsigned         prog_len;

    // Data memory model state.
    int unsigned         mem_state, mem_count, long_latency;
    logic                m_we;
    core_pkg::word_t     m_addr, m_wdata;
    bit [31:0]           lcg_state;

    // Observed and expected streams.
    core_pkg::reg_addr_t got_rd[$], exp_rd[$];
    core_pkg::word_t     got_data[$], exp_data[$];
    logic                req_we[$];
    core_pkg::word_t     req_addr[$], req_wdata[$];
    core_pkg::word_t     rf [32];

    tb_clock i_clock (
        .reset_req(reset_req),
        .clk      (clk),
        .rstN     (rstN)
    );

    pipeline_core #(.reset_pc(reset_pc)) i_dut (
        .clk         (clk),
        .rstN        (rstN),
        .imem_data   (imem_data),
        .dmem_ready  (dmem_ready),
        .dmem_rdata  (dmem_rdata),
        .imem_addr   (imem_addr),
        .dmem_valid  (dmem_valid),
        .dmem_we     (dmem_we),
        .dmem_addr   (dmem_addr),
        .dmem_wdata  (dmem_wdata),
        .retire_valid(retire_valid),
        .retire_rd   (retire_rd),
        .retire_data (retire_data)
    );

    // Combinational instruction memory.
    assign imem_data = imem[6'((imem_addr - reset_pc) >> 2)];

    // ============================================================
    // Helpers
    // ============================================================

    function automatic bit [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {17'd0, lcg_state[30:16]};
    endfunction

    function automatic core_pkg::word_t fill_word(int unsigned idx);
        return 32'hc0de_0000 ^ (core_pkg::word_t'(idx) * 32'h9e37_79b9);
    endfunction

    function automatic core_pkg::word_t enc_r(logic [6:0] f7, core_pkg::reg_addr_t rs2,
                                              core_pkg::reg_addr_t rs1, logic [2:0] f3,
                                              core_pkg::reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, core_pkg::op_reg};
    endfunction

    function automatic core_pkg::word_t enc_i(logic [11:0] imm, core_pkg::reg_addr_t rs1,
                                              logic [2:0] f3, core_pkg::reg_addr_t rd,
                                              logic [6:0] opcode);
        return {imm, rs1, f3, rd, opcode};
    endfunction

    function automatic core_pkg::word_t enc_s(logic [11:0] imm, core_pkg::reg_addr_t rs2,
                                              core_pkg::reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, core_pkg::f3_word, imm[4:0], core_pkg::op_store};
    endfunction

    function automatic core_pkg::word_t enc_b(logic [12:0] imm, core_pkg::reg_addr_t rs2,
                                              core_pkg::reg_addr_t rs1, logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], core_pkg::op_branch};
    endfunction

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic compare_word(string name, core_pkg::word_t got, core_pkg::word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic compare_reg(string name, core_pkg::reg_addr_t got,
                               core_pkg::reg_addr_t exp);
        if (got !== exp) begin
            fail_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic compare_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            fail_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic emit(core_pkg::word_t instr);
        imem[prog_len] = instr;
        prog_len++;
    endtask

    // Records an architectural register write in the reference model.
    task automatic expect_write(core_pkg::reg_addr_t rd, core_pkg::word_t value);
        rf[rd] = value;
        exp_rd.push_back(rd);
        exp_data.push_back(value);
    endtask

    task automatic start_program();
        foreach (imem[i]) begin
            imem[i] = core_pkg::nop_instr;
        end
        prog_len = 0;
        exp_rd.delete();
        exp_data.delete();
    endtask

    task automatic apply_reset();
        int unsigned cycles;
        @(posedge clk);
        reset_req <= 1'b1;
        @(posedge clk);
        reset_req <= 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > 40) begin
                fail_run("Reset never released");
            end
        end while (!rstN);
        got_rd.delete();
        got_data.delete();
        req_we.delete();
        req_addr.delete();
        req_wdata.delete();
    endtask

    task automatic check_retired();
        int unsigned cycles;
        cycles = 0;
        while (got_rd.size() < exp_rd.size()) begin
            @(negedge clk);
            cycles++;
            if (cycles > 500) begin
                fail_run("Timeout waiting for instructions to retire");
            end
        end
        // Extra cycles catch instructions that should never retire.
        repeat (12) @(negedge clk);
        compare_word("retire count", got_rd.size(), exp_rd.size());
        foreach (exp_rd[i]) begin
            compare_reg("retire_rd", got_rd[i], exp_rd[i]);
            compare_word("retire_data", got_data[i], exp_data[i]);
        end
    endtask

    // ============================================================
    // Data memory model and retirement monitor
    // ============================================================

    always @(posedge clk) begin
        if (!rstN) begin
            mem_state  <= 0;
            dmem_ready <= 1'b1;
        end else begin
            case (mem_state)
                0: begin
                    if (dmem_valid) begin
                        req_we.push_back(dmem_we);
                        req_addr.push_back(dmem_addr);
                        req_wdata.push_back(dmem_wdata);
                        m_we       <= dmem_we;
                        m_addr     <= dmem_addr;
                        m_wdata    <= dmem_wdata;
                        dmem_ready <= 1'b0;
                        mem_state  <= 1;
                        if (long_latency != 0 && !dmem_we) begin
                            mem_count <= long_latency;
                        end else begin
                            mem_count <= 1 + lcg_next() % 6;
                        end
                    end
                end
                1: begin
                    if (mem_count <= 1) begin
                        dmem_ready <= 1'b1;
                        mem_state  <= 2;
                        if (m_we) begin
                            dmem[m_addr[9:2]] <= m_wdata;
                        end else begin
                            dmem_rdata <= dmem[m_addr[9:2]];
                        end
                    end else begin
                        mem_count <= mem_count - 1;
                    end
                end
                default: begin
                    // The core consumes the completion at this edge.
                    mem_state <= 0;
                end
            endcase
        end
    end

    always @(negedge clk) begin
        if (rstN && retire_valid) begin
            got_rd.push_back(retire_rd);
            got_data.push_back(retire_data);
        end
    end

    // ============================================================
    // Directed tests
    // ============================================================

    task automatic test_reset();
        start_program();
        apply_reset();
        compare_bit("dmem_valid", dmem_valid, 1'b0);
        compare_bit("retire_valid", retire_valid, 1'b0);
        compare_word("imem_addr", imem_addr, reset_pc);
    endtask

    task automatic test_alu_sequence();
        start_program();
        emit(enc_i(12'd100, 5'd0, core_pkg::f3_add_sub, 5'd1, core_pkg::op_imm));
        expect_write(5'd1, 32'd100);
        emit(enc_i(12'hff9, 5'd1, core_pkg::f3_add_sub, 5'd2, core_pkg::op_imm));
        expect_write(5'd2, rf[1] - 32'd7);
        emit(enc_r(7'h00, 5'd2, 5'd1, core_pkg::f3_add_sub, 5'd3));
        expect_write(5'd3, rf[1] + rf[2]);
        emit(enc_r(7'h20, 5'd1, 5'd3, core_pkg::f3_add_sub, 5'd4));
        expect_write(5'd4, rf[3] - rf[1]);
        emit(enc_r(7'h00, 5'd3, 5'd4, core_pkg::f3_and, 5'd5));
        expect_write(5'd5, rf[4] & rf[3]);
        emit(enc_r(7'h00, 5'd2, 5'd5, core_pkg::f3_or, 5'd6));
        expect_write(5'd6, rf[5] | rf[2]);
        emit(enc_r(7'h00, 5'd4, 5'd6, core_pkg::f3_xor, 5'd7));
        expect_write(5'd7, rf[6] ^ rf[4]);
        apply_reset();
        check_retired();
    endtask

    task automatic test_store_load();
        logic [11:0] value;
        value = 12'(lcg_next() & 32'h7ff);
        start_program();
        emit(enc_i(12'd64, 5'd0, core_pkg::f3_add_sub, 5'd1, core_pkg::op_imm));
        expect_write(5'd1, 32'd64);
        emit(enc_i(value, 5'd0, core_pkg::f3_add_sub, 5'd2, core_pkg::op_imm));
        expect_write(5'd2, {20'd0, value});
        emit(enc_s(12'd8, 5'd2, 5'd1));
        emit(enc_i(12'd8, 5'd1, core_pkg::f3_word, 5'd3, core_pkg::op_load));
        expect_write(5'd3, rf[2]);
        emit(enc_r(7'h00, 5'd1, 5'd3, core_pkg::f3_add_sub, 5'd4));
        expect_write(5'd4, rf[3] + rf[1]);
        apply_reset();
        check_retired();
        compare_word("request count", req_we.size(), 32'd2);
        compare_bit("dmem_we", req_we[0], 1'b1);
        compare_word("dmem_addr", req_addr[0], rf[1] + 32'd8);
        compare_word("dmem_wdata", req_wdata[0], rf[2]);
        compare_bit("dmem_we", req_we[1], 1'b0);
        compare_word("dmem_addr", req_addr[1], rf[1] + 32'd8);
    endtask

    task automatic test_branches();
        start_program();
        emit(enc_i(12'd3, 5'd0, core_pkg::f3_add_sub, 5'd1, core_pkg::op_imm));
        expect_write(5'd1, 32'd3);
        emit(enc_i(12'd3, 5'd0, core_pkg::f3_add_sub, 5'd2, core_pkg::op_imm));
        expect_write(5'd2, 32'd3);
        // This BEQ is taken and skips the next two instructions.
        emit(enc_b(13'd12, 5'd2, 5'd1, core_pkg::f3_beq));
        emit(enc_i(12'd1, 5'd0, core_pkg::f3_add_sub, 5'd3, core_pkg::op_imm));
        emit(enc_i(12'd2, 5'd0, core_pkg::f3_add_sub, 5'd4, core_pkg::op_imm));
        emit(enc_i(12'd7, 5'd0, core_pkg::f3_add_sub, 5'd5, core_pkg::op_imm));
        expect_write(5'd5, 32'd7);
        // This BNE falls through because x1 equals x2.
        emit(enc_b(13'd8, 5'd2, 5'd1, core_pkg::f3_bne));
        emit(enc_i(12'd9, 5'd0, core_pkg::f3_add_sub, 5'd6, core_pkg::op_imm));
        expect_write(5'd6, 32'd9);
        apply_reset();
        check_retired();
    endtask

    task automatic test_back_pressure();
        int unsigned     cycles;
        core_pkg::word_t hold_pc, hold_addr, hold_wdata;
        start_program();
        emit(enc_i(12'd32, 5'd0, core_pkg::f3_add_sub, 5'd1, core_pkg::op_imm));
        expect_write(5'd1, 32'd32);
        emit(enc_i(12'h123, 5'd0, core_pkg::f3_add_sub, 5'd2, core_pkg::op_imm));
        expect_write(5'd2, 32'h123);
        emit(enc_s(12'd0, 5'd2, 5'd1));
        emit(enc_i(12'd0, 5'd1, core_pkg::f3_word, 5'd3, core_pkg::op_load));
        expect_write(5'd3, rf[2]);
        emit(enc_i(12'd1, 5'd3, core_pkg::f3_add_sub, 5'd4, core_pkg::op_imm));
        expect_write(5'd4, rf[3] + 32'd1);
        long_latency = 20;
        apply_reset();
        cycles = 0;
        while (!(dmem_valid && !dmem_we && !dmem_ready)) begin
            @(negedge clk);
            cycles++;
            if (cycles > 200) begin
                fail_run("Timeout waiting for the held load");
            end
        end
        hold_pc    = imem_addr;
        hold_addr  = dmem_addr;
        hold_wdata = dmem_wdata;
        repeat (19) begin
            @(negedge clk);
            compare_word("imem_addr", imem_addr, hold_pc);
            compare_bit("dmem_valid", dmem_valid, 1'b1);
            compare_bit("dmem_we", dmem_we, 1'b0);
            compare_word("dmem_addr", dmem_addr, hold_addr);
            compare_word("dmem_wdata", dmem_wdata, hold_wdata);
            compare_bit("retire_valid", retire_valid, 1'b0);
        end
        check_retired();
        long_latency = 0;
    endtask

    initial begin
        reset_req    = 1'b0;
        dmem_ready   = 1'b1;
        dmem_rdata   = '0;
        lcg_state    = 32'd26821;
        long_latency = 0;
        mem_state    = 0;
        prog_len     = 0;
        foreach (dmem[i]) begin
            dmem[i] = fill_word(i);
        end
        foreach (rf[i]) begin
            rf[i] = '0;
        end
        test_reset();
        test_alu_sequence();
        test_store_load();
        test_branches();
        test_back_pressure();
        $display("RESULT: PASS");
        $finish;
    end

endmodule : tb_pipeline_core

// File: testbench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
    input  logic reset_req,
    output logic clk,
    output logic rstN
);

    int unsigned reset_count;

    initial begin
        clk         = 1'b0;
        rstN        = 1'b0;
        reset_count = 8;
    end

    // 20 ns period.
    always #10 clk = ~clk;

    // Reset is held low for 8 cycles at start and after each request.
    always @(posedge clk) begin
        if (reset_req) begin
            reset_count <= 8;
            rstN        <= 1'b0;
        end else if (reset_count > 0) begin
            reset_count <= reset_count - 1;
            rstN        <= (reset_count == 1);
        end
    end

endmodule : tb_clock

// File: rtl/pipeline_core.sv
`timescale 1ns/1ns

module pipeline_core #(
    parameter core_pkg::word_t reset_pc = '0
) (
    input  logic                clk,
    input  logic                rstN,
    input  core_pkg::word_t     imem_data,
    input  logic                dmem_ready,
    input  core_pkg::word_t     dmem_rdata,
    output core_pkg::word_t     imem_addr,
    output logic                dmem_valid,
    output logic                dmem_we,
    output core_pkg::word_t     dmem_addr,
    output core_pkg::word_t     dmem_wdata,
    output logic                retire_valid,
    output core_pkg::reg_addr_t retire_rd,
    output core_pkg::word_t     retire_data
);

    // Fetch to decode.
    core_pkg::word_t     if_instr, if_pc;

    // Decode to execute.
    core_pkg::reg_addr_t ex_rs1, ex_rs2, ex_rd;
    core_pkg::word_t     ex_a, ex_b, ex_imm, ex_pc;
    core_pkg::alu_op_t   ex_alu_op;
    logic                ex_use_imm, ex_load, ex_store, ex_branch, ex_bne, ex_wen;

    // Execute to result.
    logic                mem_load, mem_store, mem_wen;
    core_pkg::reg_addr_t mem_rd;
    core_pkg::word_t     mem_alu, mem_wdata;
    logic                mem_done;

    // Write-back and control.
    logic                wb_en;
    core_pkg::reg_addr_t wb_rd;
    core_pkg::word_t     wb_data, branch_target;
    logic                take_branch, stall, pc_write, if_id_write, id_ex_enable;

    instr_fetch #(.reset_pc(reset_pc)) i_fetch (.*);

    instr_decode i_decode (.*);

    execute_stage i_execute (.*);

    result_stage i_result (.*);

    hazard_unit i_hazard (.*);

    // Every register write is an architectural retirement.
    assign retire_valid = wb_en;
    assign retire_rd    = wb_rd;
    assign retire_data  = wb_data;

endmodule : pipeline_core

// File: rtl/hazard_unit.sv
`timescale 1ns/1ns

module hazard_unit (
    input  logic clk,
    input  logic rstN,
    input  logic mem_load,
    input  logic mem_store,
    input  logic mem_done,
    input  logic take_branch,
    output logic pc_write,
    output logic if_id_write,
    output logic id_ex_enable,
    output logic stall
);

    typedef enum logic [2:0] {
        idle              = 3'd0,
        wait_accept_read  = 3'd1,
        read_wait         = 3'd2,
        wait_accept_write = 3'd3,
        write_wait        = 3'd4
    } state_t;

    state_t state, next_state;

    // ============================================================
    // Memory-wait FSM
    // ============================================================

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                if (mem_load && !mem_done) begin
                    next_state = wait_accept_read;
                end else if (mem_store && !mem_done) begin
                    next_state = wait_accept_write;
                end
            end
            // The memory cannot have finished in the first cycle of the request.
            wait_accept_read: begin
                next_state = mem_done ? idle : read_wait;
            end
            read_wait: begin
                if (mem_done) begin
                    next_state = idle;
                end
            end
            wait_accept_write: begin
                next_state = mem_done ? idle : write_wait;
            end
            write_wait: begin
                if (mem_done) begin
                    next_state = idle;
                end
            end
            default: begin
                next_state = idle;
            end
        endcase
    end

    // ============================================================
    // Pipeline controls
    // ============================================================

    // Release the front end in the cycle the access completes.
    assign stall = (mem_load || mem_store) && (next_state != idle);

    assign pc_write     = !stall;
    assign id_ex_enable = !stall;
    assign if_id_write  = !(stall || take_branch);

endmodule : hazard_unit

// File: rtl/result_stage.sv
`timescale 1ns/1ns

module result_stage (
    input  logic                clk,
    input  logic                rstN,
    input  logic                mem_load,
    input  logic                mem_store,
    input  logic                mem_wen,
    input  core_pkg::reg_addr_t mem_rd,
    input  core_pkg::word_t     mem_alu,
    input  core_pkg::word_t     mem_wdata,
    input  logic                dmem_ready,
    input  core_pkg::word_t     dmem_rdata,
    output logic                dmem_valid,
    output logic                dmem_we,
    output core_pkg::word_t     dmem_addr,
    output core_pkg::word_t     dmem_wdata,
    output logic                mem_done,
    output logic                wb_en,
    output core_pkg::reg_addr_t wb_rd,
    output core_pkg::word_t     wb_data
);

    logic mem_access;
    logic seen_ready_low;

    assign mem_access = mem_load || mem_store;

    // ============================================================
    // Data memory request
    // ============================================================

    // The execute/result register holds during the access,
    // so the request stays stable until completion.
    assign dmem_valid = mem_access;
    assign dmem_we    = mem_store;
    assign dmem_addr  = mem_alu;
    assign dmem_wdata = mem_wdata;

    // The memory drops ready once it has taken the request.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            seen_ready_low <= 1'b0;
        end else if (mem_done) begin
            seen_ready_low <= 1'b0;
        end else if (mem_access && !dmem_ready) begin
            seen_ready_low <= 1'b1;
        end
    end

    // Ready rising again ends the access.
    assign mem_done = mem_access && seen_ready_low && dmem_ready;

    // ============================================================
    // Write-back
    // ============================================================

    // ALU results retire at once, loads only when the data arrives.
    assign wb_en   = mem_wen && (!mem_load || mem_done);
    assign wb_rd   = mem_rd;
    assign wb_data = mem_load ? dmem_rdata : mem_alu;

endmodule : result_stage

// File: rtl/execute_stage.sv
`timescale 1ns/1ns

module execute_stage (
    input  logic                clk,
    input  logic                rstN,
    input  logic                stall,
    input  core_pkg::reg_addr_t ex_rs1,
    input  core_pkg::reg_addr_t ex_rs2,
    input  core_pkg::word_t     ex_a,
    input  core_pkg::word_t     ex_b,
    input  core_pkg::word_t     ex_imm,
    input  core_pkg::word_t     ex_pc,
    input  core_pkg::reg_addr_t ex_rd,
    input  core_pkg::alu_op_t   ex_alu_op,
    input  logic                ex_use_imm,
    input  logic                ex_load,
    input  logic                ex_store,
    input  logic                ex_branch,
    input  logic                ex_bne,
    input  logic                ex_wen,
    input  logic                wb_en,
    input  core_pkg::reg_addr_t wb_rd,
    input  core_pkg::word_t     wb_data,
    output logic                take_branch,
    output core_pkg::word_t     branch_target,
    output logic                mem_load,
    output logic                mem_store,
    output logic                mem_wen,
    output core_pkg::reg_addr_t mem_rd,
    output core_pkg::word_t     mem_alu,
    output core_pkg::word_t     mem_wdata
);

    core_pkg::word_t fwd_a, fwd_b, alu_b, alu_result;
    logic            operands_equal;

    // Forwarding from the result stage.
    assign fwd_a = (wb_en && (wb_rd != '0) && (wb_rd == ex_rs1)) ? wb_data : ex_a;
    assign fwd_b = (wb_en && (wb_rd != '0) && (wb_rd == ex_rs2)) ? wb_data : ex_b;

    assign alu_b = ex_use_imm ? ex_imm : fwd_b;

    always_comb begin
        case (ex_alu_op)
            core_pkg::alu_sub: alu_result = fwd_a - alu_b;
            core_pkg::alu_and: alu_result = fwd_a & alu_b;
            core_pkg::alu_or:  alu_result = fwd_a | alu_b;
            core_pkg::alu_xor: alu_result = fwd_a ^ alu_b;
            default:           alu_result = fwd_a + alu_b;
        endcase
    end

    // ============================================================
    // Branch resolution
    // ============================================================

    assign operands_equal = (fwd_a == fwd_b);
    assign branch_target  = ex_pc + ex_imm;

    // The branch waits while a memory access holds the pipeline.
    assign take_branch = ex_branch && (operands_equal != ex_bne) && !stall;

    // ============================================================
    // Execute/result register
    // ============================================================

    always_ff @(posedge clk) begin
        if (!rstN) begin
            mem_load  <= 1'b0;
            mem_store <= 1'b0;
            mem_wen   <= 1'b0;
        end else if (!stall) begin
            mem_load  <= ex_load;
            mem_store <= ex_store;
            mem_wen   <= ex_wen && !ex_branch;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            mem_rd    <= ex_rd;
            mem_alu   <= alu_result;
            mem_wdata <= fwd_b;
        end
    end

endmodule : execute_stage

// File: rtl/instr_decode.sv
`timescale 1ns/1ns

module instr_decode (
    input  logic                clk,
    input  logic                rstN,
    input  core_pkg::word_t     if_instr,
    input  core_pkg::word_t     if_pc,
    input  logic                id_ex_enable,
    input  logic                take_branch,
    input  logic                wb_en,
    input  core_pkg::reg_addr_t wb_rd,
    input  core_pkg::word_t     wb_data,
    output core_pkg::reg_addr_t ex_rs1,
    output core_pkg::reg_addr_t ex_rs2,
    output core_pkg::word_t     ex_a,
    output core_pkg::word_t     ex_b,
    output core_pkg::word_t     ex_imm,
    output core_pkg::word_t     ex_pc,
    output core_pkg::reg_addr_t ex_rd,
    output core_pkg::alu_op_t   ex_alu_op,
    output logic                ex_use_imm,
    output logic                ex_load,
    output logic                ex_store,
    output logic                ex_branch,
    output logic                ex_bne,
    output logic                ex_wen
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    core_pkg::reg_addr_t rs1, rs2, rd;
    core_pkg::word_t     imm_i, imm_s, imm_b, imm;
    core_pkg::word_t     rdata1, rdata2;
    core_pkg::alu_op_t   alu_op;
    logic                is_reg, is_imm, is_load, is_store, is_branch;
    logic                wen, use_imm;
    core_pkg::word_t     regs [32];

    // ============================================================
    // Field extraction and control decode
    // ============================================================

    assign opcode = if_instr[6:0];
    assign rd     = if_instr[11:7];
    assign funct3 = if_instr[14:12];
    assign rs1    = if_instr[19:15];
    assign rs2    = if_instr[24:20];

    assign is_reg    = (opcode == core_pkg::op_reg);
    assign is_imm    = (opcode == core_pkg::op_imm) && (funct3 == core_pkg::f3_add_sub);
    assign is_load   = (opcode == core_pkg::op_load) && (funct3 == core_pkg::f3_word);
    assign is_store  = (opcode == core_pkg::op_store) && (funct3 == core_pkg::f3_word);
    assign is_branch = (opcode == core_pkg::op_branch) &&
                       ((funct3 == core_pkg::f3_beq) || (funct3 == core_pkg::f3_bne));

    // Writes to x0 are dropped here so they never reach the retire port.
    assign wen     = (is_reg || is_imm || is_load) && (rd != '0);
    assign use_imm = is_imm || is_load || is_store;

    always_comb begin
        alu_op = core_pkg::alu_add;
        if (is_reg) begin
            case (funct3)
                core_pkg::f3_add_sub: alu_op = if_instr[30] ? core_pkg::alu_sub
                                                            : core_pkg::alu_add;
                core_pkg::f3_xor:     alu_op = core_pkg::alu_xor;
                core_pkg::f3_or:      alu_op = core_pkg::alu_or;
                core_pkg::f3_and:     alu_op = core_pkg::alu_and;
                default:              alu_op = core_pkg::alu_add;
            endcase
        end
    end

    // Immediates.
    assign imm_i = {{20{if_instr[31]}}, if_instr[31:20]};
    assign imm_s = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
    assign imm_b = {{19{if_instr[31]}}, if_instr[31], if_instr[7],
                    if_instr[30:25], if_instr[11:8], 1'b0};

    always_comb begin
        if (is_store) begin
            imm = imm_s;
        end else if (is_branch) begin
            imm = imm_b;
        end else begin
            imm = imm_i;
        end
    end

    // ============================================================
    // Register file
    // ============================================================

    always_ff @(posedge clk) begin
        if (wb_en && (wb_rd != '0)) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // The value retiring this cycle is seen here through write-through.
    always_comb begin
        rdata1 = regs[rs1];
        if (rs1 == '0) begin
            rdata1 = '0;
        end else if (wb_en && (wb_rd == rs1)) begin
            rdata1 = wb_data;
        end
    end

    always_comb begin
        rdata2 = regs[rs2];
        if (rs2 == '0) begin
            rdata2 = '0;
        end else if (wb_en && (wb_rd == rs2)) begin
            rdata2 = wb_data;
        end
    end

    // ============================================================
    // Decode/execute register
    // ============================================================

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ex_load   <= 1'b0;
            ex_store  <= 1'b0;
            ex_branch <= 1'b0;
            ex_bne    <= 1'b0;
            ex_wen    <= 1'b0;
        end else if (take_branch) begin
            // Squash the instruction behind the branch.
            ex_load   <= 1'b0;
            ex_store  <= 1'b0;
            ex_branch <= 1'b0;
            ex_bne    <= 1'b0;
            ex_wen    <= 1'b0;
        end else if (id_ex_enable) begin
            ex_load   <= is_load;
            ex_store  <= is_store;
            ex_branch <= is_branch;
            ex_bne    <= (funct3 == core_pkg::f3_bne);
            ex_wen    <= wen;
        end
    end

    always_ff @(posedge clk) begin
        if (id_ex_enable) begin
            ex_rs1     <= rs1;
            ex_rs2     <= rs2;
            ex_a       <= rdata1;
            ex_b       <= rdata2;
            ex_imm     <= imm;
            ex_pc      <= if_pc;
            ex_rd      <= rd;
            ex_alu_op  <= alu_op;
            ex_use_imm <= use_imm;
        end
    end

endmodule : instr_decode

// File: rtl/instr_fetch.sv
`timescale 1ns/1ns

module instr_fetch #(
    parameter core_pkg::word_t reset_pc = '0
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic            pc_write,
    input  logic            if_id_write,
    input  logic            take_branch,
    input  core_pkg::word_t branch_target,
    input  core_pkg::word_t imem_data,
    output core_pkg::word_t imem_addr,
    output core_pkg::word_t if_instr,
    output core_pkg::word_t if_pc
);

    core_pkg::word_t pc;

    // Instruction memory is combinational, so the PC is the fetch address.
    assign imem_addr = pc;

    // Program counter.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= reset_pc;
        end else if (take_branch) begin
            pc <= branch_target;
        end else if (pc_write) begin
            pc <= pc + 32'd4;
        end
    end

    // ============================================================
    // Fetch/decode register
    // ============================================================

    // A taken branch squashes the word fetched in the same cycle.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            if_instr <= core_pkg::nop_instr;
        end else if (take_branch) begin
            if_instr <= core_pkg::nop_instr;
        end else if (if_id_write) begin
            if_instr <= imem_data;
        end
    end

    always_ff @(posedge clk) begin
        if (if_id_write) begin
            if_pc <= pc;
        end
    end

endmodule : instr_fetch

// File: rtl/core_pkg.sv
package core_pkg;

    // ============================================================
    // Widths and basic types
    // ============================================================

    parameter int xlen = 32;

    typedef logic [4:0]      reg_addr_t;
    typedef logic [xlen-1:0] word_t;

    // ALU operations used by the supported subset.
    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4
    } alu_op_t;

    // ============================================================
    // RV32I encodings
    // ============================================================

    // Major opcodes in instruction bits [6:0].
    parameter logic [6:0] op_reg    = 7'b0110011;
    parameter logic [6:0] op_imm    = 7'b0010011;
    parameter logic [6:0] op_load   = 7'b0000011;
    parameter logic [6:0] op_store  = 7'b0100011;
    parameter logic [6:0] op_branch = 7'b1100011;

    // Funct3 values for R-type ALU operations.
    parameter logic [2:0] f3_add_sub = 3'b000;
    parameter logic [2:0] f3_xor     = 3'b100;
    parameter logic [2:0] f3_or      = 3'b110;
    parameter logic [2:0] f3_and     = 3'b111;

    // Funct3 values for branches.
    parameter logic [2:0] f3_beq = 3'b000;
    parameter logic [2:0] f3_bne = 3'b001;

    // Funct3 for word loads and stores.
    parameter logic [2:0] f3_word = 3'b010;

    // ADDI x0, x0, 0.
    parameter word_t nop_instr = 32'h0000_0013;

endpackage : core_pkg
